/* common/bster_pkg.sv */
/*
 * BST engine shared definitions
 * Widths, opcodes, engine states and the stored node record
 */

package bster_pkg;

    localparam int TOKEN_W   = 8;
    localparam int PAYLOAD_W = 32;
    // Also bounds the node RAM to 256 entries
    localparam int PTR_W     = 8;

    typedef logic [PTR_W-1:0] ptr_t;

    // Any other value is an unknown command
    typedef enum logic [7:0] {
        CMD_INSERT = 8'd1,
        CMD_SEARCH = 8'd2
    } cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        RD_NODE,
        WAIT_NODE,
        WR_NODE,
        COMPLETE
    } engine_state_e;

    // 58 bits per node
    typedef struct packed {
        logic [TOKEN_W-1:0]   token;
        logic [PAYLOAD_W-1:0] payload;
        ptr_t                 left;
        ptr_t                 right;
        logic                 has_left;
        logic                 has_right;
    } node_t;

endpackage

/* common/node_mem_if.sv */
/*
 * Node RAM access channel between one tree engine and the dispatcher
 */

interface node_mem_if;

    // Engine requests
    logic              valid;
    logic              wr;
    bster_pkg::ptr_t   addr;
    bster_pkg::node_t  wr_node;

    // Returned by the RAM side
    logic              ready;
    logic              rd_valid;
    bster_pkg::node_t  rd_node;

    modport engine (
        output valid,
        output wr,
        output addr,
        output wr_node,
        input  ready,
        input  rd_valid,
        input  rd_node
    );

    modport ram (
        input  valid,
        input  wr,
        input  addr,
        input  wr_node,
        output ready,
        output rd_valid,
        output rd_node
    );

endinterface

/* rtl/node_ram.sv */
/*
 * Node storage, one write or read per cycle, read data a cycle later
 */

module node_ram #(
    parameter int NODE_COUNT = 16
) (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    valid,
    input  logic                    wr,
    input  logic [((NODE_COUNT > 1) ? $clog2(NODE_COUNT) : 1)-1:0] addr,
    input  bster_pkg::node_t        wr_node,
    output logic                    rd_valid,
    output bster_pkg::node_t        rd_node
);

    bster_pkg::node_t mem [NODE_COUNT];

    always_ff @(posedge aclk) begin
        if (valid && wr) begin
            mem[addr] <= wr_node;
        end
        if (valid && !wr) begin
            rd_node <= mem[addr];
        end
    end

    // Read strobe
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= valid & ~wr;
        end
    end

endmodule

/* rtl/engine_dispatch.sv */
/*
 * Command dispatcher
 * Routes requests by opcode, holds completions and arbitrates the node RAM
 */

module engine_dispatch #(
    parameter int NODE_COUNT = 16
) (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            req_valid,
    output logic                            req_ready,
    input  bster_pkg::cmd_e                 req_cmd,
    output logic                            cpl_valid,
    input  logic                            cpl_ready,
    output logic [bster_pkg::PAYLOAD_W-1:0] cpl_data,
    output logic                            cpl_status,
    output logic                            ins_start,
    output logic                            srch_start,
    input  logic                            ins_done,
    input  logic                            srch_done,
    input  logic                            ins_status,
    input  logic                            srch_status,
    input  logic [bster_pkg::PAYLOAD_W-1:0] ins_data,
    input  logic [bster_pkg::PAYLOAD_W-1:0] srch_data,
    input  logic                            ins_tree_empty,
    output logic                            tree_empty,
    node_mem_if.ram                         ins_mem,
    node_mem_if.ram                         srch_mem,
    output logic                            ram_valid,
    output logic                            ram_wr,
    output logic [((NODE_COUNT > 1) ? $clog2(NODE_COUNT) : 1)-1:0] ram_addr,
    output bster_pkg::node_t                ram_wr_node,
    input  logic                            ram_rd_valid,
    input  bster_pkg::node_t                ram_rd_node
);

    localparam int ADDR_W = (NODE_COUNT > 1) ? $clog2(NODE_COUNT) : 1;

    logic busy;
    logic sel_ins;
    logic req_take;
    logic bad_cmd;

    // ----------------------------------------
    // Request side
    // ----------------------------------------

    assign req_ready  = ~busy;
    assign req_take   = req_valid & req_ready;
    assign ins_start  = req_take & (req_cmd == bster_pkg::CMD_INSERT);
    assign srch_start = req_take & (req_cmd == bster_pkg::CMD_SEARCH);
    assign bad_cmd    = req_take & ~ins_start & ~srch_start;

    // Busy holds until the completion leaves
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy       <= 1'b0;
            sel_ins    <= 1'b0;
            cpl_valid  <= 1'b0;
            cpl_data   <= '0;
            cpl_status <= 1'b0;
        end else begin
            if (req_take) begin
                busy    <= 1'b1;
                sel_ins <= ins_start;
            end
            if (bad_cmd) begin
                cpl_valid  <= 1'b1;
                cpl_data   <= '0;
                cpl_status <= 1'b0;
            end else if (ins_done) begin
                cpl_valid  <= 1'b1;
                cpl_data   <= ins_data;
                cpl_status <= ins_status;
            end else if (srch_done) begin
                cpl_valid  <= 1'b1;
                cpl_data   <= srch_data;
                cpl_status <= srch_status;
            end
            if (cpl_valid && cpl_ready) begin
                cpl_valid <= 1'b0;
                busy      <= 1'b0;
            end
        end
    end

    // Allocation state lives in the insert engine
    assign tree_empty = ins_tree_empty;

    // ----------------------------------------
    // Node RAM arbitration
    // ----------------------------------------

    assign ram_valid   = sel_ins ? ins_mem.valid   : srch_mem.valid;
    assign ram_wr      = sel_ins ? ins_mem.wr      : srch_mem.wr;
    assign ram_addr    = sel_ins ? ins_mem.addr[ADDR_W-1:0] : srch_mem.addr[ADDR_W-1:0];
    assign ram_wr_node = sel_ins ? ins_mem.wr_node : srch_mem.wr_node;

    assign ins_mem.ready     = 1'b1;
    assign srch_mem.ready    = 1'b1;
    assign ins_mem.rd_valid  = ram_rd_valid & sel_ins;
    assign srch_mem.rd_valid = ram_rd_valid & ~sel_ins;
    assign ins_mem.rd_node   = ram_rd_node;
    assign srch_mem.rd_node  = ram_rd_node;

endmodule

/* engines/insert_engine.sv */
/*
 * Insert engine
 * Walks the tree to overwrite a matching node or link a newly allocated leaf
 */

module insert_engine #(
    parameter int NODE_COUNT = 16
) (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            start,
    input  logic [bster_pkg::TOKEN_W-1:0]   token,
    input  logic [bster_pkg::PAYLOAD_W-1:0] payload,
    output logic                            done,
    output logic                            status,
    output logic [bster_pkg::PAYLOAD_W-1:0] result,
    output logic                            tree_empty,
    node_mem_if.engine                      mem
);

    localparam int ADDR_W = (NODE_COUNT > 1) ? $clog2(NODE_COUNT) : 1;
    localparam int CNT_W  = $clog2(NODE_COUNT + 1);

    bster_pkg::engine_state_e        state;
    logic [bster_pkg::TOKEN_W-1:0]   tok_q;
    logic [bster_pkg::PAYLOAD_W-1:0] pay_q;
    logic [ADDR_W-1:0]               cur_addr;
    logic [ADDR_W-1:0]               wr_addr;
    bster_pkg::node_t                wr_q;
    bster_pkg::node_t                par_q;
    logic                            link_q;
    logic [CNT_W-1:0]                node_cnt;
    bster_pkg::ptr_t                 new_ptr;
    logic                            go_left;
    logic                            full;

    assign tree_empty = (node_cnt == '0);
    assign full       = (node_cnt == CNT_W'(NODE_COUNT));
    assign new_ptr    = bster_pkg::ptr_t'(node_cnt[ADDR_W-1:0]);
    assign go_left    = (tok_q < mem.rd_node.token);
    assign done       = (state == bster_pkg::COMPLETE);

    assign mem.valid   = (state == bster_pkg::RD_NODE) || (state == bster_pkg::WR_NODE);
    assign mem.wr      = (state == bster_pkg::WR_NODE);
    assign mem.addr    = mem.wr ? bster_pkg::ptr_t'(wr_addr) : bster_pkg::ptr_t'(cur_addr);
    assign mem.wr_node = wr_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= bster_pkg::IDLE;
            tok_q    <= '0;
            pay_q    <= '0;
            cur_addr <= '0;
            wr_addr  <= '0;
            wr_q     <= '0;
            par_q    <= '0;
            link_q   <= 1'b0;
            node_cnt <= '0;
            status   <= 1'b0;
            result   <= '0;
        end else begin
            case (state)
                bster_pkg::IDLE: if (start) begin
                    tok_q    <= token;
                    pay_q    <= payload;
                    cur_addr <= '0;
                    if (tree_empty) begin
                        // First node becomes the root
                        wr_addr  <= '0;
                        wr_q     <= '{token: token, payload: payload, default: '0};
                        node_cnt <= node_cnt + 1'b1;
                        state    <= bster_pkg::WR_NODE;
                    end else begin
                        state <= bster_pkg::RD_NODE;
                    end
                end
                bster_pkg::RD_NODE: if (mem.ready) begin
                    state <= bster_pkg::WAIT_NODE;
                end
                bster_pkg::WAIT_NODE: if (mem.rd_valid) begin
                    if (mem.rd_node.token == tok_q) begin
                        wr_addr      <= cur_addr;
                        wr_q         <= mem.rd_node;
                        wr_q.payload <= pay_q;
                        state        <= bster_pkg::WR_NODE;
                    end else if (go_left && mem.rd_node.has_left) begin
                        cur_addr <= mem.rd_node.left[ADDR_W-1:0];
                        state    <= bster_pkg::RD_NODE;
                    end else if (!go_left && mem.rd_node.has_right) begin
                        cur_addr <= mem.rd_node.right[ADDR_W-1:0];
                        state    <= bster_pkg::RD_NODE;
                    end else if (full) begin
                        status <= 1'b0;
                        result <= '0;
                        state  <= bster_pkg::COMPLETE;
                    end else begin
                        // Leaf goes out first, parent link follows
                        wr_addr <= node_cnt[ADDR_W-1:0];
                        wr_q    <= '{token: tok_q, payload: pay_q, default: '0};
                        par_q   <= mem.rd_node;
                        if (go_left) begin
                            par_q.left     <= new_ptr;
                            par_q.has_left <= 1'b1;
                        end else begin
                            par_q.right     <= new_ptr;
                            par_q.has_right <= 1'b1;
                        end
                        link_q   <= 1'b1;
                        node_cnt <= node_cnt + 1'b1;
                        state    <= bster_pkg::WR_NODE;
                    end
                end
                bster_pkg::WR_NODE: if (mem.ready) begin
                    if (link_q) begin
                        link_q  <= 1'b0;
                        wr_addr <= cur_addr;
                        wr_q    <= par_q;
                    end else begin
                        status <= 1'b1;
                        result <= pay_q;
                        state  <= bster_pkg::COMPLETE;
                    end
                end
                default: state <= bster_pkg::IDLE;
            endcase
        end
    end

endmodule

/* engines/search_engine.sv */
/*
 * Search engine, walks from the root and returns the payload of a token
 */

module search_engine #(
    parameter int NODE_COUNT = 16
) (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            start,
    input  logic [bster_pkg::TOKEN_W-1:0]   token,
    input  logic                            tree_empty,
    output logic                            done,
    output logic                            status,
    output logic [bster_pkg::PAYLOAD_W-1:0] result,
    node_mem_if.engine                      mem
);

    localparam int ADDR_W = (NODE_COUNT > 1) ? $clog2(NODE_COUNT) : 1;

    bster_pkg::engine_state_e      state;
    logic [bster_pkg::TOKEN_W-1:0] tok_q;
    logic [ADDR_W-1:0]             cur_addr;
    logic                          go_left;

    assign go_left = (tok_q < mem.rd_node.token);
    assign done    = (state == bster_pkg::COMPLETE);

    // Read only
    assign mem.valid   = (state == bster_pkg::RD_NODE);
    assign mem.wr      = 1'b0;
    assign mem.addr    = bster_pkg::ptr_t'(cur_addr);
    assign mem.wr_node = '0;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= bster_pkg::IDLE;
            tok_q    <= '0;
            cur_addr <= '0;
            status   <= 1'b0;
            result   <= '0;
        end else begin
            case (state)
                bster_pkg::IDLE: if (start) begin
                    tok_q    <= token;
                    cur_addr <= '0;
                    status   <= 1'b0;
                    result   <= '0;
                    // Nothing stored yet, fail at once
                    state    <= tree_empty ? bster_pkg::COMPLETE : bster_pkg::RD_NODE;
                end
                bster_pkg::RD_NODE: if (mem.ready) begin
                    state <= bster_pkg::WAIT_NODE;
                end
                bster_pkg::WAIT_NODE: if (mem.rd_valid) begin
                    if (mem.rd_node.token == tok_q) begin
                        status <= 1'b1;
                        result <= mem.rd_node.payload;
                        state  <= bster_pkg::COMPLETE;
                    end else if (go_left && mem.rd_node.has_left) begin
                        cur_addr <= mem.rd_node.left[ADDR_W-1:0];
                        state    <= bster_pkg::RD_NODE;
                    end else if (!go_left && mem.rd_node.has_right) begin
                        cur_addr <= mem.rd_node.right[ADDR_W-1:0];
                        state    <= bster_pkg::RD_NODE;
                    end else begin
                        state <= bster_pkg::COMPLETE;
                    end
                end
                default: state <= bster_pkg::IDLE;
            endcase
        end
    end

endmodule

/* rtl/bst_engine.sv */
/*
 * Binary search tree engine top level
 * Request/completion ports, insert and search engines over an on-chip node RAM
 */

module bst_engine #(
    parameter int NODE_COUNT = 16
) (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            req_valid,
    output logic                            req_ready,
    input  bster_pkg::cmd_e                 req_cmd,
    input  logic [bster_pkg::TOKEN_W-1:0]   req_token,
    input  logic [bster_pkg::PAYLOAD_W-1:0] req_data,
    output logic                            cpl_valid,
    input  logic                            cpl_ready,
    output logic [bster_pkg::PAYLOAD_W-1:0] cpl_data,
    output logic                            cpl_status
);

    localparam int ADDR_W = (NODE_COUNT > 1) ? $clog2(NODE_COUNT) : 1;

    logic                            ins_start;
    logic                            ins_done;
    logic                            ins_status;
    logic [bster_pkg::PAYLOAD_W-1:0] ins_data;
    logic                            ins_tree_empty;
    logic                            srch_start;
    logic                            srch_done;
    logic                            srch_status;
    logic [bster_pkg::PAYLOAD_W-1:0] srch_data;
    logic                            tree_empty;

    logic                            ram_valid;
    logic                            ram_wr;
    logic [ADDR_W-1:0]               ram_addr;
    bster_pkg::node_t                ram_wr_node;
    logic                            ram_rd_valid;
    bster_pkg::node_t                ram_rd_node;

    node_mem_if ins_mem ();
    node_mem_if srch_mem ();

    engine_dispatch #(
        .NODE_COUNT (NODE_COUNT)
    ) u_dispatch (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_cmd        (req_cmd),
        .cpl_valid      (cpl_valid),
        .cpl_ready      (cpl_ready),
        .cpl_data       (cpl_data),
        .cpl_status     (cpl_status),
        .ins_start      (ins_start),
        .srch_start     (srch_start),
        .ins_done       (ins_done),
        .srch_done      (srch_done),
        .ins_status     (ins_status),
        .srch_status    (srch_status),
        .ins_data       (ins_data),
        .srch_data      (srch_data),
        .ins_tree_empty (ins_tree_empty),
        .tree_empty     (tree_empty),
        .ins_mem        (ins_mem.ram),
        .srch_mem       (srch_mem.ram),
        .ram_valid      (ram_valid),
        .ram_wr         (ram_wr),
        .ram_addr       (ram_addr),
        .ram_wr_node    (ram_wr_node),
        .ram_rd_valid   (ram_rd_valid),
        .ram_rd_node    (ram_rd_node)
    );

    // Token and payload go straight to the engines, start marks the cycle
    insert_engine #(
        .NODE_COUNT (NODE_COUNT)
    ) u_insert (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .start      (ins_start),
        .token      (req_token),
        .payload    (req_data),
        .done       (ins_done),
        .status     (ins_status),
        .result     (ins_data),
        .tree_empty (ins_tree_empty),
        .mem        (ins_mem.engine)
    );

    search_engine #(
        .NODE_COUNT (NODE_COUNT)
    ) u_search (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .start      (srch_start),
        .token      (req_token),
        .tree_empty (tree_empty),
        .done       (srch_done),
        .status     (srch_status),
        .result     (srch_data),
        .mem        (srch_mem.engine)
    );

    node_ram #(
        .NODE_COUNT (NODE_COUNT)
    ) u_node_ram (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .valid    (ram_valid),
        .wr       (ram_wr),
        .addr     (ram_addr),
        .wr_node  (ram_wr_node),
        .rd_valid (ram_rd_valid),
        .rd_node  (ram_rd_node)
    );

endmodule

/* bench/bst_model.svh */
/*
 * BST reference model
 * Stored tokens, node capacity and expected completions
 */

`ifndef BST_MODEL_SVH
`define BST_MODEL_SVH

// Token to payload, one entry per stored node
logic [bster_pkg::PAYLOAD_W-1:0] stored_payload [int];
int                              stored_count;

function automatic void clear_tree();
    stored_payload.delete();
    stored_count = 0;
endfunction

// Expected completion of one command, updates the stored tokens
function automatic void predict_completion(
    input  bster_pkg::cmd_e                 cmd,
    input  logic [bster_pkg::TOKEN_W-1:0]   token,
    input  logic [bster_pkg::PAYLOAD_W-1:0] data,
    input  int                              capacity,
    output logic                            exp_status,
    output logic [bster_pkg::PAYLOAD_W-1:0] exp_data
);
    exp_status = 1'b0;
    exp_data   = '0;
    if (cmd == bster_pkg::CMD_INSERT) begin
        if (stored_payload.exists(int'(token))) begin
            stored_payload[int'(token)] = data;
            exp_status = 1'b1;
            exp_data   = data;
        end else if (stored_count < capacity) begin
            stored_payload[int'(token)] = data;
            stored_count++;
            exp_status = 1'b1;
            exp_data   = data;
        end
    end else if (cmd == bster_pkg::CMD_SEARCH) begin
        if (stored_payload.exists(int'(token))) begin
            exp_status = 1'b1;
            exp_data   = stored_payload[int'(token)];
        end
    end
endfunction

`endif

/* bench/tb_bst_engine.sv */
/*
 * BST engine testbench
 * Random inserts, searches and unknown opcodes checked against a model
 */

module tb_bst_engine;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NODE_COUNT     = 16;
    localparam int NUM_OPS        = 400;
    localparam int TOKEN_MAX      = 31;
    localparam int TIMEOUT_CYCLES = NUM_OPS * (4 * NODE_COUNT + 20);

    logic                            aclk;
    logic                            aresetn;
    logic                            req_valid;
    logic                            req_ready;
    bster_pkg::cmd_e                 req_cmd;
    logic [bster_pkg::TOKEN_W-1:0]   req_token;
    logic [bster_pkg::PAYLOAD_W-1:0] req_data;
    logic                            cpl_valid;
    logic                            cpl_ready;
    logic [bster_pkg::PAYLOAD_W-1:0] cpl_data;
    logic                            cpl_status;

    string test_name;
    int    op_num;
    int    cycles = 0;

    `include "bst_model.svh"

    bst_engine #(
        .NODE_COUNT (NODE_COUNT)
    ) dut (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_cmd    (req_cmd),
        .req_token  (req_token),
        .req_data   (req_data),
        .cpl_valid  (cpl_valid),
        .cpl_ready  (cpl_ready),
        .cpl_data   (cpl_data),
        .cpl_status (cpl_status)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else
            abort_run($sformatf("** Error %s op %0d %s expected %h actual %h",
                                test_name, op_num, what, expected, actual));
    endtask

    // ----------------------------------------
    // One command, request to completion
    // ----------------------------------------

    task automatic run_command(input bster_pkg::cmd_e cmd,
                               input logic [bster_pkg::TOKEN_W-1:0] token,
                               input logic [bster_pkg::PAYLOAD_W-1:0] data);
        logic                            exp_status;
        logic [bster_pkg::PAYLOAD_W-1:0] exp_data;
        logic                            seen;
        logic                            taken;
        logic [bster_pkg::PAYLOAD_W-1:0] held_data;
        logic                            held_status;
        seen        = 1'b0;
        taken       = 1'b0;
        held_data   = '0;
        held_status = 1'b0;
        op_num++;
        predict_completion(cmd, token, data, NODE_COUNT, exp_status, exp_data);
        assert (req_ready && !cpl_valid) else
            abort_run("DUT not idle when a new request was due");
        req_valid = 1'b1;
        req_cmd   = cmd;
        req_token = token;
        req_data  = data;
        @(negedge aclk);
        // Junk on the request fields once the request is taken
        req_valid = 1'b0;
        req_token = 8'($urandom);
        req_data  = $urandom;
        if (cmd != bster_pkg::CMD_INSERT && cmd != bster_pkg::CMD_SEARCH) begin
            assert (cpl_valid) else
                abort_run("No completion one cycle after an unknown opcode");
        end
        while (!taken) begin
            assert (!req_ready) else
                abort_run("req_ready high while a command is in flight");
            if (cpl_valid) begin
                if (!seen) begin
                    seen        = 1'b1;
                    held_data   = cpl_data;
                    held_status = cpl_status;
                    check_value("cpl_status", 32'(exp_status), 32'(cpl_status));
                    check_value("cpl_data", exp_data, cpl_data);
                end else begin
                    assert (cpl_data === held_data && cpl_status === held_status) else
                        abort_run("Completion changed while cpl_ready was low");
                end
            end else begin
                assert (!seen) else
                    abort_run("cpl_valid dropped before the completion was taken");
            end
            cpl_ready = 1'($urandom_range(0, 1));
            taken     = cpl_valid && cpl_ready;
            @(negedge aclk);
        end
        assert (!cpl_valid) else
            abort_run("More than one completion for a single request");
    endtask

    // Run length limit
    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            abort_run("Timeout, the run did not finish within the cycle limit");
        end
    end

    initial begin
        int unsigned     seed;
        int              pick;
        bster_pkg::cmd_e cmd;
        req_valid = 1'b0;
        req_cmd   = bster_pkg::CMD_SEARCH;
        req_token = '0;
        req_data  = '0;
        cpl_ready = 1'b0;
        aresetn   = 1'b0;
        op_num    = 0;
        test_name = "reset";
        seed      = $urandom(32'h2f);
        clear_tree();
        repeat (8) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        assert (req_ready && !cpl_valid) else
            abort_run("req_ready or cpl_valid wrong right after reset");

        test_name = "directed";
        run_command(bster_pkg::CMD_SEARCH, 8'd9, 32'h0);
        run_command(bster_pkg::CMD_INSERT, 8'd9, 32'h1234_5678);
        run_command(bster_pkg::CMD_SEARCH, 8'd9, 32'h0);
        run_command(bster_pkg::CMD_INSERT, 8'd9, 32'hcafe_0001);
        run_command(bster_pkg::CMD_SEARCH, 8'd9, 32'h0);
        run_command(bster_pkg::cmd_e'(8'h7f), 8'd9, 32'hdead_beef);
        run_command(bster_pkg::CMD_SEARCH, 8'd9, 32'h0);

        // Tokens span twice the capacity, so the tree fills up
        test_name = "random";
        for (int i = 0; i < NUM_OPS; i++) begin
            pick = $urandom_range(0, 9);
            if (pick < 5) begin
                cmd = bster_pkg::CMD_INSERT;
            end else if (pick < 9) begin
                cmd = bster_pkg::CMD_SEARCH;
            end else begin
                cmd = bster_pkg::cmd_e'(8'($urandom_range(3, 255)));
            end
            run_command(cmd, 8'($urandom_range(0, TOKEN_MAX)), $urandom);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+bench
common/bster_pkg.sv
common/node_mem_if.sv
rtl/node_ram.sv
rtl/engine_dispatch.sv
engines/insert_engine.sv
engines/search_engine.sv
rtl/bst_engine.sv
bench/tb_bst_engine.sv

/* Bender.yml */
package:
  name: bst_engine

sources:
  - files:
      - common/bster_pkg.sv
      - common/node_mem_if.sv
      - rtl/node_ram.sv
      - rtl/engine_dispatch.sv
      - engines/insert_engine.sv
      - engines/search_engine.sv
      - rtl/bst_engine.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_bst_engine.sv
